// File: design/fp_fwd_pkg.sv
// Shared types for the FP operand forwarding unit
// The FP register file has 32 entries and no hardwired zero register
// Enum encodings are fixed widths so they can be probed in waveforms

package fp_fwd_pkg;

  // ========================================
  // Register index and operand count
  // ========================================

  // Index of one of the 32 FP registers f0 to f31
  typedef logic [4:0] fp_reg_idx_t;

  // Source operands of an FP instruction, fs1 fs2 and fs3 for fused multiply-add
  localparam int unsigned NUM_FP_SRCS = 3;

  // ========================================
  // Load capture buffer states
  // ========================================

  // IDLE holds nothing, HOLD keeps a finished load until the pipeline advances,
  // CLEARING gives the consumer one more cycle before the entry is dropped
  typedef enum logic [1:0] {
    CAP_IDLE     = 2'd0,
    CAP_HOLD     = 2'd1,
    CAP_CLEARING = 2'd2
  } load_cap_state_e;

  // ========================================
  // Operand source choice
  // ========================================

  // Listed in priority order, highest first
  typedef enum logic [2:0] {
    SRC_MA_LOAD      = 3'd0,
    SRC_MA_RESULT    = 3'd1,
    SRC_MA_PIPE      = 3'd2,
    SRC_WB           = 3'd3,
    SRC_LOAD_CAPTURE = 3'd4,
    SRC_REGFILE      = 3'd5
  } fwd_src_e;

endpackage : fp_fwd_pkg

// File: design/fp_fwd_unit.sv
// FP operand forwarding unit for the instruction in EX
// Operand outputs are combinational from the inputs and internal state
// o_fwd_stall must be merged into i_stall by the pipeline control logic

`timescale 1ns/1ns

module fp_fwd_unit
  import fp_fwd_pkg::*;
#(
  parameter int unsigned FP_WIDTH = 32
) (
  input  logic                i_clk,
  input  logic                i_arst_n,
  // Pipeline control
  input  logic                i_stall,
  input  logic                i_load_use_stall,
  input  logic                i_flush,
  // Early sources of the instruction in Predecode
  input  fp_reg_idx_t         i_pd_rs1,
  input  fp_reg_idx_t         i_pd_rs2,
  input  fp_reg_idx_t         i_pd_rs3,
  // Producer in EX
  input  fp_reg_idx_t         i_ex_rd,
  input  logic                i_ex_is_load,
  input  logic                i_ex_wen,
  input  logic [FP_WIDTH-1:0] i_ex_result,
  // Sources of the consumer in EX
  input  fp_reg_idx_t         i_ex_rs1,
  input  fp_reg_idx_t         i_ex_rs2,
  input  fp_reg_idx_t         i_ex_rs3,
  // Producer in MA
  input  logic                i_ma_wen,
  input  fp_reg_idx_t         i_ma_rd,
  input  logic                i_ma_is_load,
  input  logic [FP_WIDTH-1:0] i_ma_result,
  input  logic [FP_WIDTH-1:0] i_ma_load_data,
  input  logic                i_ma_load_valid,
  // Producer in WB
  input  logic                i_wb_wen,
  input  fp_reg_idx_t         i_wb_rd,
  input  logic [FP_WIDTH-1:0] i_wb_data,
  // Register file read data
  input  logic [FP_WIDTH-1:0] i_rf_data1,
  input  logic [FP_WIDTH-1:0] i_rf_data2,
  input  logic [FP_WIDTH-1:0] i_rf_data3,
  // Forwarded operands and stall request
  output logic [FP_WIDTH-1:0] o_fwd_data1,
  output logic [FP_WIDTH-1:0] o_fwd_data2,
  output logic [FP_WIDTH-1:0] o_fwd_data3,
  output logic                o_fwd_stall
);

  logic [NUM_FP_SRCS-1:0] ma_flag;
  logic [NUM_FP_SRCS-1:0] wb_flag;
  logic [FP_WIDTH-1:0]    ma_pipe_data;
  logic                   use_pipe_for_load;
  logic                   cap_valid;
  fp_reg_idx_t            cap_rd;
  logic [FP_WIDTH-1:0]    cap_data;

  // Per-operand views of the loose operand ports, index 0 is fs1
  fp_reg_idx_t         ex_rs    [NUM_FP_SRCS];
  logic [FP_WIDTH-1:0] rf_data  [NUM_FP_SRCS];
  logic [FP_WIDTH-1:0] fwd_data [NUM_FP_SRCS];

  assign ex_rs[0]    = i_ex_rs1;
  assign ex_rs[1]    = i_ex_rs2;
  assign ex_rs[2]    = i_ex_rs3;
  assign rf_data[0]  = i_rf_data1;
  assign rf_data[1]  = i_rf_data2;
  assign rf_data[2]  = i_rf_data3;
  assign o_fwd_data1 = fwd_data[0];
  assign o_fwd_data2 = fwd_data[1];
  assign o_fwd_data3 = fwd_data[2];

  // ========================================
  // Shared state
  // ========================================

  fp_hazard_detect fp_hazard_detect_inst (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_stall     (i_stall),
    .i_flush     (i_flush),
    .i_pd_rs1    (i_pd_rs1),
    .i_pd_rs2    (i_pd_rs2),
    .i_pd_rs3    (i_pd_rs3),
    .i_ex_rd     (i_ex_rd),
    .i_ma_rd     (i_ma_rd),
    .i_ex_wen    (i_ex_wen),
    .i_ex_is_load(i_ex_is_load),
    .i_ma_wen    (i_ma_wen),
    .o_ma_flag   (ma_flag),
    .o_wb_flag   (wb_flag)
  );

  fp_ma_data_pipe #(.FP_WIDTH(FP_WIDTH)) fp_ma_data_pipe_inst (
    .i_clk              (i_clk),
    .i_arst_n           (i_arst_n),
    .i_stall            (i_stall),
    .i_load_use_stall   (i_load_use_stall),
    .i_ma_is_load       (i_ma_is_load),
    .i_ex_wen           (i_ex_wen),
    .i_ma_load_data     (i_ma_load_data),
    .i_ex_result        (i_ex_result),
    .o_pipe_data        (ma_pipe_data),
    .o_use_pipe_for_load(use_pipe_for_load),
    .o_fwd_stall        (o_fwd_stall)
  );

  fp_load_capture #(.FP_WIDTH(FP_WIDTH)) fp_load_capture_inst (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_stall        (i_stall),
    .i_ma_is_load   (i_ma_is_load),
    .i_ma_load_valid(i_ma_load_valid),
    .i_ma_rd        (i_ma_rd),
    .i_ma_load_data (i_ma_load_data),
    .o_cap_valid    (cap_valid),
    .o_cap_rd       (cap_rd),
    .o_cap_data     (cap_data)
  );

  // ========================================
  // Operand selectors
  // ========================================

  for (genvar g = 0; g < NUM_FP_SRCS; g++) begin : g_sel
    fp_operand_select #(.FP_WIDTH(FP_WIDTH)) fp_operand_select_inst (
      .i_ex_rs            (ex_rs[g]),
      .i_ma_flag          (ma_flag[g]),
      .i_wb_flag          (wb_flag[g]),
      .i_ma_wen           (i_ma_wen),
      .i_ma_is_load       (i_ma_is_load),
      .i_wb_wen           (i_wb_wen),
      .i_use_pipe_for_load(use_pipe_for_load),
      .i_cap_valid        (cap_valid),
      .i_ma_rd            (i_ma_rd),
      .i_wb_rd            (i_wb_rd),
      .i_cap_rd           (cap_rd),
      .i_ma_result        (i_ma_result),
      .i_ma_load_data     (i_ma_load_data),
      .i_pipe_data        (ma_pipe_data),
      .i_wb_data          (i_wb_data),
      .i_cap_data         (cap_data),
      .i_rf_data          (rf_data[g]),
      .o_data             (fwd_data[g])
    );
  end

endmodule : fp_fwd_unit

// File: design/fp_hazard_detect.sv
// Registered RAW hazard flags for the three FP source operands
// Flags are computed from Predecode source indices and are valid once the
// consumer reaches EX; they hold under stall and clear on flush

`timescale 1ns/1ns

module fp_hazard_detect
  import fp_fwd_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_stall,
  input  logic                   i_flush,
  input  fp_reg_idx_t            i_pd_rs1,
  input  fp_reg_idx_t            i_pd_rs2,
  input  fp_reg_idx_t            i_pd_rs3,
  input  fp_reg_idx_t            i_ex_rd,
  input  fp_reg_idx_t            i_ma_rd,
  input  logic                   i_ex_wen,
  input  logic                   i_ex_is_load,
  input  logic                   i_ma_wen,
  output logic [NUM_FP_SRCS-1:0] o_ma_flag,
  output logic [NUM_FP_SRCS-1:0] o_wb_flag
);

  // Early source indices gathered so each operand is handled by the same loop
  fp_reg_idx_t pd_rs [NUM_FP_SRCS];

  // Hazard decisions for the instruction now in Predecode
  logic [NUM_FP_SRCS-1:0] ma_hit;
  logic [NUM_FP_SRCS-1:0] wb_hit;

  // The EX producer writes the register either as a compute result or a load
  logic ex_writes;

  assign pd_rs[0] = i_pd_rs1;
  assign pd_rs[1] = i_pd_rs2;
  assign pd_rs[2] = i_pd_rs3;

  assign ex_writes = i_ex_wen | i_ex_is_load;

  // ========================================
  // Hazard compare
  // ========================================

  // When the consumer moves from Predecode to EX, the producer now in EX will
  // sit in MA and the producer now in MA will sit in WB
  always_comb begin
    for (int i = 0; i < NUM_FP_SRCS; i++) begin
      ma_hit[i] = ex_writes && (i_ex_rd == pd_rs[i]);
      wb_hit[i] = i_ma_wen && (i_ma_rd == pd_rs[i]);
    end
  end

  // ========================================
  // Flag registers
  // ========================================

  // Flush wins over stall so a squashed consumer never inherits stale flags
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ma_flag <= '0;
      o_wb_flag <= '0;
    end else if (i_flush) begin
      o_ma_flag <= '0;
      o_wb_flag <= '0;
    end else if (!i_stall) begin
      o_ma_flag <= ma_hit;
      o_wb_flag <= wb_hit;
    end
  end

endmodule : fp_hazard_detect

// File: design/fp_load_capture.sv
// One-entry buffer for the most recent completed FP load
// Covers a consumer that reaches EX after the load has already left MA
// A newer load always overwrites the entry, whatever the current state

`timescale 1ns/1ns

module fp_load_capture
  import fp_fwd_pkg::*;
#(
  parameter int unsigned FP_WIDTH = 32
) (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_stall,
  input  logic                i_ma_is_load,
  input  logic                i_ma_load_valid,
  input  fp_reg_idx_t         i_ma_rd,
  input  logic [FP_WIDTH-1:0] i_ma_load_data,
  output logic                o_cap_valid,
  output fp_reg_idx_t         o_cap_rd,
  output logic [FP_WIDTH-1:0] o_cap_data
);

  load_cap_state_e state;
  load_cap_state_e state_next;

  // The load has its data back from memory in this cycle
  logic load_done;

  assign load_done = i_ma_is_load && i_ma_load_valid;

  // ========================================
  // State machine
  // ========================================

  always_comb begin
    state_next = state;
    if (load_done) begin
      state_next = CAP_HOLD;
    end else begin
      case (state)
        // Keep the entry through any stall, start clearing once EX advances
        CAP_HOLD:     if (!i_stall) state_next = CAP_CLEARING;
        CAP_CLEARING: state_next = CAP_IDLE;
        default:      state_next = CAP_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= CAP_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Destination and data are only meaningful while the entry is valid
  always_ff @(posedge i_clk) begin
    if (load_done) begin
      o_cap_rd   <= i_ma_rd;
      o_cap_data <= i_ma_load_data;
    end
  end

  assign o_cap_valid = (state != CAP_IDLE);

endmodule : fp_load_capture

// File: design/fp_ma_data_pipe.sv
// Two-stage register pipe for data forwarded from MA into the operand muxes
// Each capture costs one stall cycle while stage 1 moves into stage 2
// A capture that arrives while a move is pending only refreshes stage 1

`timescale 1ns/1ns

module fp_ma_data_pipe #(
  parameter int unsigned FP_WIDTH = 32
) (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_stall,
  input  logic                i_load_use_stall,
  input  logic                i_ma_is_load,
  input  logic                i_ex_wen,
  input  logic [FP_WIDTH-1:0] i_ma_load_data,
  input  logic [FP_WIDTH-1:0] i_ex_result,
  output logic [FP_WIDTH-1:0] o_pipe_data,
  output logic                o_use_pipe_for_load,
  output logic                o_fwd_stall
);

  // Load data is taken during the load-use stall so it stays stable afterwards
  logic load_capture;
  // A compute result is taken when EX advances and writes an FP register
  logic result_capture;
  logic capture;

  // Stage 1 catches the data, stage 2 drives the wide fanout
  logic [FP_WIDTH-1:0] stage1_data;
  logic [FP_WIDTH-1:0] stage2_data;
  logic                pending;

  assign load_capture   = i_load_use_stall && i_ma_is_load;
  assign result_capture = !i_stall && i_ex_wen;
  assign capture        = load_capture || result_capture;

  // ========================================
  // Data stages
  // ========================================

  // Load data takes precedence when both conditions hold in the same cycle
  always_ff @(posedge i_clk) begin
    if (load_capture) begin
      stage1_data <= i_ma_load_data;
    end else if (result_capture) begin
      stage1_data <= i_ex_result;
    end
  end

  always_ff @(posedge i_clk) begin
    if (pending) begin
      stage2_data <= stage1_data;
    end
  end

  // ========================================
  // Pending flag and load-use delay
  // ========================================

  // Pending lasts exactly one cycle, so the stall never repeats back to back
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pending             <= 1'b0;
      o_use_pipe_for_load <= 1'b0;
    end else begin
      if (pending) begin
        pending <= 1'b0;
      end else if (capture) begin
        pending <= 1'b1;
      end
      // Registered so the selectors never feed back into stall generation
      o_use_pipe_for_load <= i_load_use_stall;
    end
  end

  assign o_pipe_data = stage2_data;
  assign o_fwd_stall = pending;

endmodule : fp_ma_data_pipe

// File: design/fp_operand_select.sv
// Priority mux for one forwarded FP source operand
// Purely combinational; every registered flag is qualified by a live index
// compare, so a stale flag can never select data for the wrong register

`timescale 1ns/1ns

module fp_operand_select
  import fp_fwd_pkg::*;
#(
  parameter int unsigned FP_WIDTH = 32
) (
  input  fp_reg_idx_t         i_ex_rs,
  input  logic                i_ma_flag,
  input  logic                i_wb_flag,
  input  logic                i_ma_wen,
  input  logic                i_ma_is_load,
  input  logic                i_wb_wen,
  input  logic                i_use_pipe_for_load,
  input  logic                i_cap_valid,
  input  fp_reg_idx_t         i_ma_rd,
  input  fp_reg_idx_t         i_wb_rd,
  input  fp_reg_idx_t         i_cap_rd,
  input  logic [FP_WIDTH-1:0] i_ma_result,
  input  logic [FP_WIDTH-1:0] i_ma_load_data,
  input  logic [FP_WIDTH-1:0] i_pipe_data,
  input  logic [FP_WIDTH-1:0] i_wb_data,
  input  logic [FP_WIDTH-1:0] i_cap_data,
  input  logic [FP_WIDTH-1:0] i_rf_data,
  output logic [FP_WIDTH-1:0] o_data
);

  // Live index compares against each possible producer
  logic ma_match;
  logic wb_match;
  logic cap_match;

  fwd_src_e src_sel;

  assign ma_match  = (i_ma_rd == i_ex_rs);
  assign wb_match  = (i_wb_rd == i_ex_rs);
  assign cap_match = i_cap_valid && (i_cap_rd == i_ex_rs);

  // ========================================
  // Source choice
  // ========================================

  // Newer producers win, MA first, then WB, then the buffered load
  always_comb begin
    if (i_ma_is_load && ma_match) begin
      src_sel = SRC_MA_LOAD;
    end else if (i_ma_wen && !i_ma_is_load && ma_match) begin
      src_sel = SRC_MA_RESULT;
    end else if (i_ma_flag && ma_match) begin
      src_sel = SRC_MA_PIPE;
    end else if ((i_wb_flag || i_wb_wen) && wb_match) begin
      // The WB write enable alone also bypasses, for consumers held by a long stall
      src_sel = SRC_WB;
    end else if (cap_match) begin
      src_sel = SRC_LOAD_CAPTURE;
    end else begin
      src_sel = SRC_REGFILE;
    end
  end

  // ========================================
  // Data mux
  // ========================================

  always_comb begin
    case (src_sel)
      // Right after a load-use stall the load data sits in stage 2 of the pipe
      SRC_MA_LOAD:      o_data = i_use_pipe_for_load ? i_pipe_data : i_ma_load_data;
      SRC_MA_RESULT:    o_data = i_ma_result;
      SRC_MA_PIPE:      o_data = i_pipe_data;
      SRC_WB:           o_data = i_wb_data;
      SRC_LOAD_CAPTURE: o_data = i_cap_data;
      default:          o_data = i_rf_data;
    endcase
  end

endmodule : fp_operand_select

// File: fp_fwd_unit.f
design/fp_fwd_pkg.sv
design/fp_hazard_detect.sv
design/fp_ma_data_pipe.sv
design/fp_load_capture.sv
design/fp_operand_select.sv
design/fp_fwd_unit.sv
verification/fp_fwd_unit_assertions.sv
verification/fp_fwd_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the FP forwarding unit testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f fp_fwd_unit.f --top-module fp_fwd_unit_tb \
  -Mdir obj_dir -o fp_fwd_unit_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/fp_fwd_unit_sim > sim.log 2>&1
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: verification/fp_fwd_unit_assertions.sv
// Concurrent checks on the forwarding stall request, bound into fp_fwd_unit
// Assumes o_fwd_stall is driven only by the MA data pipe pending flag

`timescale 1ns/1ns

module fp_fwd_unit_assertions (
  input logic i_clk,
  input logic i_arst_n,
  input logic i_stall,
  input logic i_load_use_stall,
  input logic i_ma_is_load,
  input logic i_ex_wen,
  input logic o_fwd_stall
);

  // A cycle in which forward data enters stage 1 of the pipe
  logic capture_cycle;

  assign capture_cycle = (i_load_use_stall && i_ma_is_load) || (!i_stall && i_ex_wen);

  // ========================================
  // Stall pulse shape
  // ========================================

  stall_single_cycle: assert property (
    @(posedge i_clk) disable iff (!i_arst_n) o_fwd_stall |=> !o_fwd_stall
  ) else $error("o_fwd_stall stayed high for two cycles");

  stall_low_after_reset: assert property (
    @(posedge i_clk) $rose(i_arst_n) |-> !o_fwd_stall
  ) else $error("o_fwd_stall high in the first cycle after reset");

  // Every stall pulse is caused by a capture one cycle earlier
  stall_after_capture: assert property (
    @(posedge i_clk) disable iff (!i_arst_n) o_fwd_stall |-> $past(capture_cycle)
  ) else $error("o_fwd_stall raised without a capture cycle before it");

endmodule : fp_fwd_unit_assertions

bind fp_fwd_unit fp_fwd_unit_assertions fp_fwd_unit_assertions_inst (
  .i_clk           (i_clk),
  .i_arst_n        (i_arst_n),
  .i_stall         (i_stall),
  .i_load_use_stall(i_load_use_stall),
  .i_ma_is_load    (i_ma_is_load),
  .i_ex_wen        (i_ex_wen),
  .o_fwd_stall     (o_fwd_stall)
);

// File: verification/fp_fwd_unit_tb.sv
// Table-driven testbench for the FP forwarding unit, FP_WIDTH fixed at 32
// Each row is one clock cycle and the expected values come from a cycle model
// The model runs over the whole table before any row is driven

`timescale 1ns/1ns

module fp_fwd_unit_tb
  import fp_fwd_pkg::*;
();

  localparam int FP_WIDTH     = 32;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_ROWS     = 20;
  localparam int MAX_CYCLES   = NUM_ROWS + RESET_CYCLES + 20;

  // One cycle of stimulus plus the expected response
  typedef struct packed {
    logic                                stall;
    logic                                lus;
    logic                                flush;
    logic [NUM_FP_SRCS-1:0][4:0]         pd_rs;
    logic [4:0]                          ex_rd;
    logic                                ex_is_load;
    logic                                ex_wen;
    logic [FP_WIDTH-1:0]                 ex_result;
    logic [NUM_FP_SRCS-1:0][4:0]         ex_rs;
    logic                                ma_wen;
    logic [4:0]                          ma_rd;
    logic                                ma_is_load;
    logic [FP_WIDTH-1:0]                 ma_result;
    logic [FP_WIDTH-1:0]                 ma_load_data;
    logic                                ma_load_valid;
    logic                                wb_wen;
    logic [4:0]                          wb_rd;
    logic [FP_WIDTH-1:0]                 wb_data;
    logic [NUM_FP_SRCS-1:0][FP_WIDTH-1:0] rf_data;
    logic [NUM_FP_SRCS-1:0][FP_WIDTH-1:0] exp_data;
    logic                                exp_stall;
  } row_t;

  row_t tbl [NUM_ROWS];
  int   errors      = 0;
  int   cycle_count = 0;

  logic                i_clk;
  logic                i_arst_n;
  logic                i_stall;
  logic                i_load_use_stall;
  logic                i_flush;
  fp_reg_idx_t         i_pd_rs1;
  fp_reg_idx_t         i_pd_rs2;
  fp_reg_idx_t         i_pd_rs3;
  fp_reg_idx_t         i_ex_rd;
  logic                i_ex_is_load;
  logic                i_ex_wen;
  logic [FP_WIDTH-1:0] i_ex_result;
  fp_reg_idx_t         i_ex_rs1;
  fp_reg_idx_t         i_ex_rs2;
  fp_reg_idx_t         i_ex_rs3;
  logic                i_ma_wen;
  fp_reg_idx_t         i_ma_rd;
  logic                i_ma_is_load;
  logic [FP_WIDTH-1:0] i_ma_result;
  logic [FP_WIDTH-1:0] i_ma_load_data;
  logic                i_ma_load_valid;
  logic                i_wb_wen;
  fp_reg_idx_t         i_wb_rd;
  logic [FP_WIDTH-1:0] i_wb_data;
  logic [FP_WIDTH-1:0] i_rf_data1;
  logic [FP_WIDTH-1:0] i_rf_data2;
  logic [FP_WIDTH-1:0] i_rf_data3;
  logic [FP_WIDTH-1:0] o_fwd_data1;
  logic [FP_WIDTH-1:0] o_fwd_data2;
  logic [FP_WIDTH-1:0] o_fwd_data3;
  logic                o_fwd_stall;

  // Reference state, advanced once per row as the DUT would at the clock edge
  logic [NUM_FP_SRCS-1:0] m_ma_flag;
  logic [NUM_FP_SRCS-1:0] m_wb_flag;
  logic [FP_WIDTH-1:0]    m_stage1;
  logic [FP_WIDTH-1:0]    m_stage2;
  logic                   m_pending;
  logic                   m_use_pipe;
  load_cap_state_e        m_cap_state;
  logic [4:0]             m_cap_rd;
  logic [FP_WIDTH-1:0]    m_cap_data;

  fp_fwd_unit #(.FP_WIDTH(FP_WIDTH)) fp_fwd_unit_inst (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // Hard limit in case the stimulus loop never finishes
  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  // ========================================
  // Reference model
  // ========================================

  // Nothing in flight, sources f1 f2 f3, random data everywhere
  function automatic row_t idle_row();
    row_t r;
    r = '0;
    r.pd_rs        = {5'd3, 5'd2, 5'd1};
    r.ex_rs        = {5'd3, 5'd2, 5'd1};
    r.ex_result    = $urandom();
    r.ma_result    = $urandom();
    r.ma_load_data = $urandom();
    r.wb_data      = $urandom();
    for (int k = 0; k < NUM_FP_SRCS; k++) begin
      r.rf_data[k] = $urandom();
    end
    return r;
  endfunction

  // Operand value from the priority rules, using the model state of this cycle
  function automatic logic [FP_WIDTH-1:0] expected_operand(row_t r, int k);
    logic ma_hit;
    logic wb_hit;
    ma_hit = (r.ma_rd == r.ex_rs[k]);
    wb_hit = (r.wb_rd == r.ex_rs[k]);
    if (r.ma_is_load && ma_hit) begin
      return m_use_pipe ? m_stage2 : r.ma_load_data;
    end
    if (r.ma_wen && !r.ma_is_load && ma_hit) begin
      return r.ma_result;
    end
    if (m_ma_flag[k] && ma_hit) begin
      return m_stage2;
    end
    if ((m_wb_flag[k] || r.wb_wen) && wb_hit) begin
      return r.wb_data;
    end
    if (m_cap_state != CAP_IDLE && m_cap_rd == r.ex_rs[k]) begin
      return m_cap_data;
    end
    return r.rf_data[k];
  endfunction

  // Clock edge at the end of a row
  task automatic advance_model(row_t r);
    logic load_cap;
    logic capture;
    load_cap = r.lus && r.ma_is_load;
    capture  = load_cap || (!r.stall && r.ex_wen);
    for (int k = 0; k < NUM_FP_SRCS; k++) begin
      if (r.flush) begin
        m_ma_flag[k] = 1'b0;
        m_wb_flag[k] = 1'b0;
      end else if (!r.stall) begin
        m_ma_flag[k] = (r.ex_wen || r.ex_is_load) && (r.ex_rd == r.pd_rs[k]);
        m_wb_flag[k] = r.ma_wen && (r.ma_rd == r.pd_rs[k]);
      end
    end
    // Stage 2 takes the old stage 1 value, so it moves first
    if (m_pending) begin
      m_stage2 = m_stage1;
    end
    if (load_cap) begin
      m_stage1 = r.ma_load_data;
    end else if (capture) begin
      m_stage1 = r.ex_result;
    end
    m_pending  = m_pending ? 1'b0 : capture;
    m_use_pipe = r.lus;
    if (r.ma_is_load && r.ma_load_valid) begin
      m_cap_state = CAP_HOLD;
      m_cap_rd    = r.ma_rd;
      m_cap_data  = r.ma_load_data;
    end else if (m_cap_state == CAP_HOLD && !r.stall) begin
      m_cap_state = CAP_CLEARING;
    end else if (m_cap_state == CAP_CLEARING) begin
      m_cap_state = CAP_IDLE;
    end
  endtask

  // ========================================
  // Stimulus table
  // ========================================

  task automatic build_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      tbl[r] = idle_row();
    end
    // Rows 0 and 1 are quiet, so every operand comes from the register file
    // WB write to f2 bypasses operand 2
    tbl[2].wb_wen = 1'b1;
    tbl[2].wb_rd  = 5'd2;
    // MA and WB both write f3, MA is newer and wins
    tbl[3].ma_wen = 1'b1;
    tbl[3].ma_rd  = 5'd3;
    tbl[3].wb_wen = 1'b1;
    tbl[3].wb_rd  = 5'd3;
    // The MA write to f3 has reached WB, the registered WB flag alone bypasses operand 3
    tbl[4].wb_rd  = 5'd3;
    // EX produces f2 for a consumer in Predecode, one stall cycle follows
    tbl[5].ex_wen = 1'b1;
    tbl[5].ex_rd  = 5'd2;
    tbl[6].stall  = 1'b1;
    tbl[7].ma_rd  = 5'd2;
    // Plain MA load to f1, then a two-cycle load-use stall on the same load
    for (int r = 8; r <= 11; r++) begin
      tbl[r].ma_is_load    = 1'b1;
      tbl[r].ma_rd         = 5'd1;
      tbl[r].ma_load_valid = 1'b1;
    end
    tbl[9].stall         = 1'b1;
    tbl[9].lus           = 1'b1;
    tbl[10].stall        = 1'b1;
    tbl[10].lus          = 1'b1;
    tbl[10].ma_load_data = tbl[9].ma_load_data;
    // The load has left MA, the buffer serves f1 through a stall and then clears
    tbl[12].stall = 1'b1;
    // Flush drops the flag that the EX write to f3 would have set
    tbl[16].flush  = 1'b1;
    tbl[16].ex_wen = 1'b1;
    tbl[16].ex_rd  = 5'd3;
    tbl[17].stall  = 1'b1;
    tbl[17].ma_rd  = 5'd3;
  endtask

  task automatic run_model();
    m_ma_flag   = '0;
    m_wb_flag   = '0;
    m_stage1    = 'x;
    m_stage2    = 'x;
    m_pending   = 1'b0;
    m_use_pipe  = 1'b0;
    m_cap_state = CAP_IDLE;
    m_cap_rd    = '0;
    m_cap_data  = 'x;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int k = 0; k < NUM_FP_SRCS; k++) begin
        tbl[r].exp_data[k] = expected_operand(tbl[r], k);
      end
      tbl[r].exp_stall = m_pending;
      advance_model(tbl[r]);
    end
  endtask

  // ========================================
  // Drive and check
  // ========================================

  task automatic apply_row(row_t r);
    i_stall          <= r.stall;
    i_load_use_stall <= r.lus;
    i_flush          <= r.flush;
    i_pd_rs1         <= r.pd_rs[0];
    i_pd_rs2         <= r.pd_rs[1];
    i_pd_rs3         <= r.pd_rs[2];
    i_ex_rd          <= r.ex_rd;
    i_ex_is_load     <= r.ex_is_load;
    i_ex_wen         <= r.ex_wen;
    i_ex_result      <= r.ex_result;
    i_ex_rs1         <= r.ex_rs[0];
    i_ex_rs2         <= r.ex_rs[1];
    i_ex_rs3         <= r.ex_rs[2];
    i_ma_wen         <= r.ma_wen;
    i_ma_rd          <= r.ma_rd;
    i_ma_is_load     <= r.ma_is_load;
    i_ma_result      <= r.ma_result;
    i_ma_load_data   <= r.ma_load_data;
    i_ma_load_valid  <= r.ma_load_valid;
    i_wb_wen         <= r.wb_wen;
    i_wb_rd          <= r.wb_rd;
    i_wb_data        <= r.wb_data;
    i_rf_data1       <= r.rf_data[0];
    i_rf_data2       <= r.rf_data[1];
    i_rf_data3       <= r.rf_data[2];
  endtask

  task automatic check_row(int r);
    logic [FP_WIDTH-1:0] got [NUM_FP_SRCS];
    got[0] = o_fwd_data1;
    got[1] = o_fwd_data2;
    got[2] = o_fwd_data3;
    for (int k = 0; k < NUM_FP_SRCS; k++) begin
      if (got[k] !== tbl[r].exp_data[k]) begin
        errors++;
        $display("Error at %0t ns: row %0d operand %0d is %h, expected %h",
                 $time, r, k + 1, got[k], tbl[r].exp_data[k]);
      end
    end
    if (o_fwd_stall !== tbl[r].exp_stall) begin
      errors++;
      $display("Error at %0t ns: row %0d o_fwd_stall is %b, expected %b",
               $time, r, o_fwd_stall, tbl[r].exp_stall);
    end
  endtask

  initial begin
    void'($urandom(32'h8757));
    build_table();
    run_model();
    i_arst_n = 1'b0;
    apply_row(idle_row());
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_arst_n <= 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge i_clk);
      apply_row(tbl[r]);
      // Sample late in the cycle, well after the combinational outputs settle
      #(CLK_PERIOD - 10);
      check_row(r);
    end
    $display("Checked %0d rows, %0d errors", NUM_ROWS, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : fp_fwd_unit_tb
